// File: index_check.f
+incdir+logic
logic/index_pkg.sv
logic/index_lane_if.sv
logic/request_capture.sv
logic/dram_port.sv
logic/index_lane.sv
logic/check_control.sv
logic/index_check.sv
test/tb_index_check.sv

// File: Makefile
TOP := tb_index_check

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f index_check.f --top-module index_check

sim:
	verilator --binary --timing --assert -Wno-fatal -f index_check.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: test/tb_index_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

module tb_index_check;

    localparam int F_ACTION  = 0;
    localparam int F_FORMULA = 1;
    localparam int F_MODE    = 2;
    localparam int F_DATE    = 3;
    localparam int F_DATA_NO = 4;
    localparam int F_INDEX   = 5;
    localparam int MAX_WAIT  = 200;

    logic               clk;
    logic               inf;
    logic [`IN_W-1:0]   in_data;
    logic               action_valid;
    logic               formula_valid;
    logic               mode_valid;
    logic               date_valid;
    logic               data_no_valid;
    logic               index_valid;
    logic               ar_valid;
    logic [`ADDR_W-1:0] ar_addr;
    logic               ar_ready;
    logic               r_valid;
    logic [`DATA_W-1:0] r_data;
    logic               r_ready;
    logic               aw_valid;
    logic [`ADDR_W-1:0] aw_addr;
    logic               aw_ready;
    logic               w_valid;
    logic [`DATA_W-1:0] w_data;
    logic               w_ready;
    logic               b_valid;
    logic               b_ready;
    logic               out_valid;
    logic               complete;
    index_pkg::warn_t   warn_msg;

    logic [`DATA_W-1:0] mem [256];
    int                 wr_count;
    int                 ar_wait;
    int                 r_wait;
    int                 aw_wait;
    int                 w_wait;
    int                 b_wait;
    logic               rd_busy;
    logic               b_pend;
    logic [7:0]         rd_idx;
    logic [7:0]         wr_idx;

    // Current request and what it should produce
    index_pkg::action_t   req_act;
    index_pkg::formula_t  req_frm;
    index_pkg::mode_t     req_mode;
    index_pkg::date_t     req_date;
    logic [7:0]           req_no;
    logic [`IDX_W-1:0]    req_idx [`LANES];
    index_pkg::warn_t     exp_warn;
    index_pkg::dram_rec_t exp_rec;
    logic [`ADDR_W-1:0]   exp_addr;

    index_check i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
        assert (got === want)
            else fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, want));
    endtask

    assert property (@(posedge clk) disable iff (!inf) out_valid |=> !out_valid)
        else fail_run("out_valid stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (!inf) !out_valid |-> !complete)
        else fail_run($sformatf("Mismatch complete: got %h expected 0", $sampled(complete)));
    assert property (@(posedge clk) disable iff (!inf)
        !out_valid |-> warn_msg == index_pkg::No_Warn)
        else fail_run($sformatf("Mismatch warn_msg: got %h expected 0", $sampled(warn_msg)));
    assert property (@(posedge clk) disable iff (!inf) ar_valid |-> ar_addr == exp_addr)
        else fail_run($sformatf("Mismatch ar_addr: got %h expected %h",
                                $sampled(ar_addr), $sampled(exp_addr)));
    assert property (@(posedge clk) disable iff (!inf) aw_valid |-> aw_addr == exp_addr)
        else fail_run($sformatf("Mismatch aw_addr: got %h expected %h",
                                $sampled(aw_addr), $sampled(exp_addr)));

    function automatic logic [7:0] record_of(input logic [`ADDR_W-1:0] addr);
        logic [`ADDR_W-1:0] offset;
        offset = addr - `DRAM_BASE;
        return offset[10:3];
    endfunction

    function automatic logic [`DATA_W-1:0] random_record();
        index_pkg::dram_rec_t rec;
        rec         = '0;
        rec.index_0 = `IDX_W'($urandom);
        rec.index_1 = `IDX_W'($urandom);
        rec.index_2 = `IDX_W'($urandom);
        rec.index_3 = `IDX_W'($urandom);
        rec.month   = 4'(1 + $urandom % 12);
        rec.day     = 5'(1 + $urandom % 28);
        return rec;
    endfunction

    function automatic logic date_is_later(input index_pkg::dram_rec_t rec,
                                           input index_pkg::date_t dt);
        if (rec.month != dt.month)
            return rec.month > dt.month;
        return rec.day > dt.day;
    endfunction

    function automatic int mode_threshold(input logic counting, input index_pkg::mode_t md);
        case (md)
            index_pkg::Insensitive: return counting ? `THR_CNT_INS : `THR_A_INS;
            index_pkg::Normal:      return counting ? `THR_CNT_NRM : `THR_A_NRM;
            default:                return counting ? `THR_CNT_SEN : `THR_A_SEN;
        endcase
    endfunction

    // Reference model
    task automatic predict_result();
        index_pkg::dram_rec_t rec;
        logic [`IDX_W-1:0]    stored [`LANES];
        logic                 counting;
        logic                 clamped;
        int                   value;
        int                   sum;
        rec       = index_pkg::dram_rec_t'(mem[req_no]);
        stored[0] = rec.index_0;
        stored[1] = rec.index_1;
        stored[2] = rec.index_2;
        stored[3] = rec.index_3;
        exp_warn  = index_pkg::No_Warn;
        exp_rec   = rec;
        counting  = (req_frm == index_pkg::Formula_D) || (req_frm == index_pkg::Formula_E);
        if (req_act == index_pkg::Update) begin
            clamped = 1'b0;
            for (int i = 0; i < `LANES; i++) begin
                sum = int'(stored[i]) + int'($signed(req_idx[i]));
                if (sum < 0 || sum > 4095)
                    clamped = 1'b1;
                sum       = (sum < 0) ? 0 : ((sum > 4095) ? 4095 : sum);
                stored[i] = `IDX_W'(sum);
            end
            exp_rec.index_0 = stored[0];
            exp_rec.index_1 = stored[1];
            exp_rec.index_2 = stored[2];
            exp_rec.index_3 = stored[3];
            exp_rec.pad_0   = '0;
            exp_rec.pad_1   = '0;
            exp_rec.month   = req_date.month;
            exp_rec.day     = req_date.day;
            if (clamped)
                exp_warn = index_pkg::Data_Warn;
        end else if (date_is_later(rec, req_date)) begin
            exp_warn = index_pkg::Date_Warn;
        end else if (req_act == index_pkg::Index_Check) begin
            value = 0;
            for (int i = 0; i < `LANES; i++) begin
                case (req_frm)
                    index_pkg::Formula_D: value += (stored[i] >= 12'd2047) ? 1 : 0;
                    index_pkg::Formula_E: value += (stored[i] >= req_idx[i]) ? 1 : 0;
                    default:              value += int'(stored[i]);
                endcase
            end
            if (!counting)
                value = value / 4;   // Floor of the mean
            if (value >= mode_threshold(counting, req_mode))
                exp_warn = index_pkg::Risk_Warn;
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic pulse_strobe(input int field, input logic [`IN_W-1:0] value);
        in_data = value;
        case (field)
            F_ACTION:  action_valid  = 1'b1;
            F_FORMULA: formula_valid = 1'b1;
            F_MODE:    mode_valid    = 1'b1;
            F_DATE:    date_valid    = 1'b1;
            F_DATA_NO: data_no_valid = 1'b1;
            default:   index_valid   = 1'b1;
        endcase
        @(negedge clk);
        action_valid  = 1'b0;
        formula_valid = 1'b0;
        mode_valid    = 1'b0;
        date_valid    = 1'b0;
        data_no_valid = 1'b0;
        index_valid   = 1'b0;
        in_data       = '0;
    endtask

    task automatic run_request();
        int writes_before;
        int wait_cycles;
        predict_result();
        exp_addr      = `DRAM_BASE + `ADDR_W'(req_no) * `ADDR_W'(8);
        writes_before = wr_count;
        pulse_strobe(F_ACTION, `IN_W'(req_act));
        if (req_act == index_pkg::Index_Check) begin
            pulse_strobe(F_FORMULA, `IN_W'(req_frm));
            pulse_strobe(F_MODE, `IN_W'(req_mode));
        end
        pulse_strobe(F_DATE, `IN_W'(req_date));
        pulse_strobe(F_DATA_NO, `IN_W'(req_no));
        if (req_act != index_pkg::Check_Valid_Date) begin
            for (int i = 0; i < `LANES; i++)
                pulse_strobe(F_INDEX, req_idx[i]);
        end
        wait_cycles = 0;
        while (!out_valid) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > MAX_WAIT)
                fail_run("Timed out waiting for out_valid");
        end
        check_value("warn_msg", 64'(warn_msg), 64'(exp_warn));
        check_value("complete", 64'(complete), 64'(exp_warn == index_pkg::No_Warn));
        if (req_act == index_pkg::Update) begin
            check_value("write count", 64'(wr_count), 64'(writes_before + 1));
        end else begin
            check_value("write count", 64'(wr_count), 64'(writes_before));
        end
        repeat (2) @(negedge clk);
    endtask

    // Memory model answering each handshake after 0 to 3 cycles
    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        rd_busy  = 1'b0;
        b_pend   = 1'b0;
        wr_count = 0;
        forever begin
            @(negedge clk);
            if (!inf) begin
                ar_ready = 1'b0;
                r_valid  = 1'b0;
                aw_ready = 1'b0;
                w_ready  = 1'b0;
                b_valid  = 1'b0;
                rd_busy  = 1'b0;
                b_pend   = 1'b0;
                ar_wait  = $urandom % 4;
                r_wait   = $urandom % 4;
                aw_wait  = $urandom % 4;
                w_wait   = $urandom % 4;
                b_wait   = $urandom % 4;
            end else begin
                if (ar_ready) begin              // Address taken at the last rising edge
                    ar_ready = 1'b0;
                    ar_wait  = $urandom % 4;
                    rd_busy  = 1'b1;
                end else if (ar_valid) begin
                    if (ar_wait == 0) begin
                        ar_ready = 1'b1;
                        rd_idx   = record_of(ar_addr);
                    end else begin
                        ar_wait--;
                    end
                end
                if (r_valid) begin
                    r_valid = 1'b0;
                    r_wait  = $urandom % 4;
                end else if (rd_busy && r_ready) begin
                    if (r_wait == 0) begin
                        r_valid = 1'b1;
                        r_data  = mem[rd_idx];
                        rd_busy = 1'b0;
                    end else begin
                        r_wait--;
                    end
                end
                if (aw_ready) begin
                    aw_ready = 1'b0;
                    aw_wait  = $urandom % 4;
                end else if (aw_valid) begin
                    if (aw_wait == 0) begin
                        aw_ready = 1'b1;
                        wr_idx   = record_of(aw_addr);
                    end else begin
                        aw_wait--;
                    end
                end
                if (w_ready) begin
                    w_ready = 1'b0;
                    w_wait  = $urandom % 4;
                    check_value("w_data", w_data, exp_rec);
                    mem[wr_idx] = w_data;
                    wr_count++;
                    b_pend = 1'b1;
                end else if (w_valid) begin
                    if (w_wait == 0)
                        w_ready = 1'b1;
                    else
                        w_wait--;
                end
                if (b_valid) begin
                    b_valid = 1'b0;
                    b_wait  = $urandom % 4;
                end else if (b_pend) begin
                    if (b_wait == 0) begin
                        assert (b_ready)
                            else fail_run("b_ready was low when a write response was due");
                        b_valid = 1'b1;
                        b_pend  = 1'b0;
                    end else begin
                        b_wait--;
                    end
                end
            end
        end
    end

    initial begin
        logic [1:0] pick;
        void'($urandom(69683));
        inf           = 1'b0;
        in_data       = '0;
        action_valid  = 1'b0;
        formula_valid = 1'b0;
        mode_valid    = 1'b0;
        date_valid    = 1'b0;
        data_no_valid = 1'b0;
        index_valid   = 1'b0;
        exp_addr      = `DRAM_BASE;
        exp_rec       = '0;
        for (int a = 0; a < 256; a++)
            mem[a] = random_record();
        repeat (2) @(posedge clk);
        @(negedge clk);
        inf = 1'b1;
        @(negedge clk);
        check_value("ar_valid", 64'(ar_valid), 64'(0));
        check_value("aw_valid", 64'(aw_valid), 64'(0));
        check_value("w_valid", 64'(w_valid), 64'(0));
        check_value("r_ready", 64'(r_ready), 64'(0));
        check_value("out_valid", 64'(out_valid), 64'(0));
        @(negedge clk);
        for (int n = 0; n < 150; n++) begin
            pick     = 2'($urandom % 3);
            req_act  = index_pkg::action_t'(pick);
            req_frm  = index_pkg::formula_t'(3'($urandom % 8));
            pick     = 2'($urandom % 3);
            req_mode = index_pkg::mode_t'((pick == 2'd2) ? 2'd3 : pick);  // 2 is not a mode
            req_date.month = 4'(1 + $urandom % 12);
            req_date.day   = 5'(1 + $urandom % 28);
            req_no   = 8'($urandom);
            for (int i = 0; i < `LANES; i++)
                req_idx[i] = `IDX_W'($urandom);
            run_request();
            if (req_act == index_pkg::Update) begin
                // Read back the record just written
                req_act = index_pkg::Check_Valid_Date;
                run_request();
                req_act = index_pkg::Index_Check;
                req_frm = index_pkg::Formula_A;
                run_request();
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/index_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

module index_check (
    input  logic               clk,
    input  logic               inf,
    input  logic [`IN_W-1:0]   in_data,
    input  logic               action_valid,
    input  logic               formula_valid,
    input  logic               mode_valid,
    input  logic               date_valid,
    input  logic               data_no_valid,
    input  logic               index_valid,
    output logic               ar_valid,
    output logic [`ADDR_W-1:0] ar_addr,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  logic [`DATA_W-1:0] r_data,
    output logic               r_ready,
    output logic               aw_valid,
    output logic [`ADDR_W-1:0] aw_addr,
    input  logic               aw_ready,
    output logic               w_valid,
    output logic [`DATA_W-1:0] w_data,
    input  logic               w_ready,
    input  logic               b_valid,
    output logic               b_ready,
    output logic               out_valid,
    output logic               complete,
    output index_pkg::warn_t   warn_msg
);
    index_pkg::action_t   action;
    index_pkg::formula_t  formula;
    index_pkg::mode_t     mode;
    index_pkg::date_t     req_date;
    index_pkg::date_t     stored_date;
    logic [7:0]           data_no;
    logic                 start;
    logic                 rd_done;
    index_pkg::dram_rec_t rd_data;
    logic                 upd_go;
    index_pkg::dram_rec_t upd_rec;
    logic                 wr_done;

    index_lane_if lanes ();

    request_capture u_capture (
        .clk(clk), .inf(inf), .in_data(in_data),
        .action_valid(action_valid), .formula_valid(formula_valid),
        .mode_valid(mode_valid), .date_valid(date_valid),
        .data_no_valid(data_no_valid), .index_valid(index_valid),
        .rd_done(rd_done), .rd_data(rd_data),
        .action(action), .formula(formula), .mode(mode), .req_date(req_date),
        .data_no(data_no), .stored_date(stored_date), .start(start),
        .lanes(lanes.feed)
    );

    dram_port u_dram (
        .clk(clk), .inf(inf), .data_no(data_no), .action(action),
        .data_no_valid(data_no_valid),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready),
        .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_data(w_data), .w_ready(w_ready),
        .b_valid(b_valid), .b_ready(b_ready),
        .upd_go(upd_go), .upd_rec(upd_rec),
        .rd_done(rd_done), .rd_data(rd_data), .wr_done(wr_done)
    );

    // One lane per stored index
    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        index_lane #(.LANE(i)) u_lane (
            .clk(clk),
            .lanes(lanes.lane)
        );
    end

    check_control u_ctrl (
        .clk(clk), .inf(inf), .start(start),
        .action(action), .formula(formula), .mode(mode),
        .req_date(req_date), .stored_date(stored_date), .wr_done(wr_done),
        .lanes(lanes.drain),
        .upd_go(upd_go), .upd_rec(upd_rec),
        .out_valid(out_valid), .complete(complete), .warn_msg(warn_msg)
    );

endmodule

`default_nettype wire

// File: logic/check_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

module check_control (
    input  logic                 clk,
    input  logic                 inf,
    input  logic                 start,
    input  index_pkg::action_t   action,
    input  index_pkg::formula_t  formula,
    input  index_pkg::mode_t     mode,
    input  index_pkg::date_t     req_date,
    input  index_pkg::date_t     stored_date,
    input  logic                 wr_done,
    index_lane_if.drain          lanes,
    output logic                 upd_go,
    output index_pkg::dram_rec_t upd_rec,
    output logic                 out_valid,
    output logic                 complete,
    output index_pkg::warn_t     warn_msg
);
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_WAIT  = 3'd1;   // Lane results settle
    localparam logic [2:0] ST_EVAL  = 3'd2;
    localparam logic [2:0] ST_WRITE = 3'd3;
    localparam logic [2:0] ST_OUT   = 3'd4;
    localparam int         CNT_W    = $clog2(`LANES + 1);

    logic [2:0]        cs, ns;
    logic [`IDX_W:0]   sum_lo, sum_hi;
    logic [`IDX_W+1:0] sum_all;
    logic [CNT_W-1:0]  cnt_ge, cnt_max;
    logic              any_sat;
    logic [`IDX_W-1:0] res, thr;
    logic              date_warn, data_warn, risk_warn;
    index_pkg::warn_t  warn_next;
    logic              cnt_formula;

    always_comb begin
        sum_lo  = lanes.dram_index[0] + lanes.dram_index[1];
        sum_hi  = lanes.dram_index[2] + lanes.dram_index[3];
        sum_all = sum_lo + sum_hi;
        cnt_ge  = '0;
        cnt_max = '0;
        any_sat = 1'b0;
        for (int i = 0; i < `LANES; i++) begin
            cnt_ge  = cnt_ge + CNT_W'(lanes.ge[i]);
            cnt_max = cnt_max + CNT_W'(lanes.at_max[i]);
            any_sat = any_sat | lanes.sat[i];
        end
    end

    always_ff @(posedge clk) begin
        if (cs == ST_WAIT) begin
            case (formula)
                index_pkg::Formula_D: res <= `IDX_W'(cnt_max);
                index_pkg::Formula_E: res <= `IDX_W'(cnt_ge);
                default:              res <= sum_all[`IDX_W+1:2];   // Floor of mean
            endcase
            date_warn <= stored_date > req_date;
            data_warn <= any_sat;
        end
    end

    assign cnt_formula = (formula == index_pkg::Formula_D) || (formula == index_pkg::Formula_E);

    always_comb begin
        case (mode)
            index_pkg::Insensitive: thr = cnt_formula ? `IDX_W'(`THR_CNT_INS) : `IDX_W'(`THR_A_INS);
            index_pkg::Normal:      thr = cnt_formula ? `IDX_W'(`THR_CNT_NRM) : `IDX_W'(`THR_A_NRM);
            default:                thr = cnt_formula ? `IDX_W'(`THR_CNT_SEN) : `IDX_W'(`THR_A_SEN);
        endcase
        risk_warn = res >= thr;
    end

    // Date warning wins over risk
    always_comb begin
        warn_next = index_pkg::No_Warn;
        if (action == index_pkg::Update) begin
            if (data_warn)
                warn_next = index_pkg::Data_Warn;
        end else if (date_warn) begin
            warn_next = index_pkg::Date_Warn;
        end else if (action == index_pkg::Index_Check && risk_warn) begin
            warn_next = index_pkg::Risk_Warn;
        end
    end

    always_comb begin
        case (cs)
            ST_IDLE:  ns = start ? ST_WAIT : ST_IDLE;
            ST_WAIT:  ns = ST_EVAL;
            ST_EVAL:  ns = (action == index_pkg::Update) ? ST_WRITE : ST_OUT;
            ST_WRITE: ns = wr_done ? ST_OUT : ST_WRITE;
            default:  ns = ST_IDLE;
        endcase
    end

    assign upd_go = (cs == ST_EVAL) && (action == index_pkg::Update);

    always_comb begin
        upd_rec.index_0 = lanes.upd_sum[0];
        upd_rec.index_1 = lanes.upd_sum[1];
        upd_rec.pad_0   = '0;
        upd_rec.month   = req_date.month;
        upd_rec.index_2 = lanes.upd_sum[2];
        upd_rec.index_3 = lanes.upd_sum[3];
        upd_rec.pad_1   = '0;
        upd_rec.day     = req_date.day;
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            cs        <= ST_IDLE;
            out_valid <= 1'b0;
            complete  <= 1'b0;
            warn_msg  <= index_pkg::No_Warn;
        end else begin
            cs        <= ns;
            out_valid <= (ns == ST_OUT);
            complete  <= (ns == ST_OUT) && (warn_next == index_pkg::No_Warn);
            warn_msg  <= (ns == ST_OUT) ? warn_next : index_pkg::No_Warn;
        end
    end

endmodule

`default_nettype wire

// File: logic/index_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

module index_lane #(
    parameter int LANE = 0
) (
    input  logic       clk,
    index_lane_if.lane lanes
);
    localparam logic [`IDX_W-1:0] HIGH_LEVEL = `IDX_W'(2047);

    logic        [`IDX_W-1:0] stored;
    logic        [`IDX_W-1:0] req;
    logic signed [`IDX_W+1:0] sum_full;   // Room for both overflow directions
    logic                     ge_q;
    logic                     at_max_q;
    logic                     sat_q;
    logic        [`IDX_W-1:0] sum_q;

    assign req      = lanes.req_index[LANE];
    assign sum_full = $signed({2'b00, stored}) + $signed({{2{req[`IDX_W-1]}}, req});

    always_ff @(posedge clk) begin
        if (lanes.load[LANE])
            stored <= lanes.dram_index[LANE];
        ge_q     <= stored >= req;
        at_max_q <= stored >= HIGH_LEVEL;
        sat_q    <= sum_full[`IDX_W+1] || sum_full[`IDX_W];
        if (sum_full[`IDX_W+1])
            sum_q <= '0;                // Below zero
        else if (sum_full[`IDX_W])
            sum_q <= '1;                // Above 4095
        else
            sum_q <= sum_full[`IDX_W-1:0];
    end

    assign lanes.ge[LANE]      = ge_q;
    assign lanes.at_max[LANE]  = at_max_q;
    assign lanes.upd_sum[LANE] = sum_q;
    assign lanes.sat[LANE]     = sat_q;

endmodule

`default_nettype wire

// File: logic/dram_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

module dram_port (
    input  logic                 clk,
    input  logic                 inf,
    input  logic [7:0]           data_no,
    input  index_pkg::action_t   action,
    input  logic                 data_no_valid,
    output logic                 ar_valid,
    output logic [`ADDR_W-1:0]   ar_addr,
    input  logic                 ar_ready,
    input  logic                 r_valid,
    input  logic [`DATA_W-1:0]   r_data,
    output logic                 r_ready,
    output logic                 aw_valid,
    output logic [`ADDR_W-1:0]   aw_addr,
    input  logic                 aw_ready,
    output logic                 w_valid,
    output logic [`DATA_W-1:0]   w_data,
    input  logic                 w_ready,
    input  logic                 b_valid,
    output logic                 b_ready,
    input  logic                 upd_go,
    input  index_pkg::dram_rec_t upd_rec,
    output logic                 rd_done,
    output index_pkg::dram_rec_t rd_data,
    output logic                 wr_done
);
    localparam logic [1:0] RD_IDLE = 2'd0;
    localparam logic [1:0] RD_ADDR = 2'd1;
    localparam logic [1:0] RD_DATA = 2'd2;

    localparam logic [2:0] WR_IDLE = 3'd0;
    localparam logic [2:0] WR_ADDR = 3'd1;
    localparam logic [2:0] WR_WAIT = 3'd2;   // Waiting for the updated record
    localparam logic [2:0] WR_DATA = 3'd3;
    localparam logic [2:0] WR_RESP = 3'd4;

    logic [1:0]         rd_cs, rd_ns;
    logic [2:0]         wr_cs, wr_ns;
    logic               no_seen;   // data_no is latched from here on
    logic               go_pend;
    logic [`ADDR_W-1:0] rec_addr;

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            rd_cs   <= RD_IDLE;
            wr_cs   <= WR_IDLE;
            no_seen <= 1'b0;
            go_pend <= 1'b0;
            rd_done <= 1'b0;
            b_ready <= 1'b0;
        end else begin
            rd_cs   <= rd_ns;
            wr_cs   <= wr_ns;
            no_seen <= data_no_valid;
            go_pend <= (wr_cs == WR_WAIT) ? 1'b0 : (go_pend | upd_go);
            rd_done <= r_valid && r_ready;
            b_ready <= 1'b1;
        end
    end

    always_comb begin
        case (rd_cs)
            RD_IDLE: rd_ns = no_seen ? RD_ADDR : RD_IDLE;
            RD_ADDR: rd_ns = ar_ready ? RD_DATA : RD_ADDR;
            RD_DATA: rd_ns = r_valid ? RD_IDLE : RD_DATA;
            default: rd_ns = RD_IDLE;
        endcase
    end

    always_comb begin
        case (wr_cs)
            WR_IDLE: wr_ns = (no_seen && action == index_pkg::Update) ? WR_ADDR : WR_IDLE;
            WR_ADDR: wr_ns = aw_ready ? WR_WAIT : WR_ADDR;
            WR_WAIT: wr_ns = (upd_go || go_pend) ? WR_DATA : WR_WAIT;
            WR_DATA: wr_ns = w_ready ? WR_RESP : WR_DATA;
            WR_RESP: wr_ns = (b_valid && b_ready) ? WR_IDLE : WR_RESP;
            default: wr_ns = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        rec_addr <= `DRAM_BASE + `ADDR_W'({data_no, 3'b000});
        if (r_valid && r_ready)
            rd_data <= index_pkg::dram_rec_t'(r_data);
        if (upd_go)
            w_data <= upd_rec;
    end

    assign ar_addr  = rec_addr;
    assign aw_addr  = rec_addr;
    assign ar_valid = (rd_cs == RD_ADDR);
    assign r_ready  = (rd_cs == RD_DATA);
    assign aw_valid = (wr_cs == WR_ADDR);
    assign w_valid  = (wr_cs == WR_DATA);
    assign wr_done  = (wr_cs == WR_RESP) && b_valid && b_ready;

endmodule

`default_nettype wire

// File: logic/request_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

module request_capture (
    input  logic                 clk,
    input  logic                 inf,
    input  logic [`IN_W-1:0]     in_data,
    input  logic                 action_valid,
    input  logic                 formula_valid,
    input  logic                 mode_valid,
    input  logic                 date_valid,
    input  logic                 data_no_valid,
    input  logic                 index_valid,
    input  logic                 rd_done,
    input  index_pkg::dram_rec_t rd_data,
    output index_pkg::action_t   action,
    output index_pkg::formula_t  formula,
    output index_pkg::mode_t     mode,
    output index_pkg::date_t     req_date,
    output logic [7:0]           data_no,
    output index_pkg::date_t     stored_date,
    output logic                 start,
    index_lane_if.feed           lanes
);
    localparam int CNT_W = $clog2(`LANES + 1);
    localparam int SEL_W = $clog2(`LANES);

    logic [CNT_W-1:0] idx_cnt;
    logic             have_rec;
    logic             fired;     // start already sent for this request
    logic             req_done;

    always_ff @(posedge clk) begin
        if (action_valid)
            action <= index_pkg::action_t'(in_data[1:0]);
        if (formula_valid)
            formula <= index_pkg::formula_t'(in_data[2:0]);
        if (mode_valid)
            mode <= index_pkg::mode_t'(in_data[1:0]);
        if (date_valid)
            req_date <= index_pkg::date_t'(in_data[8:0]);   // Month 8:5, day 4:0
        if (data_no_valid)
            data_no <= in_data[7:0];
        if (index_valid)
            lanes.req_index[idx_cnt[SEL_W-1:0]] <= in_data[`IDX_W-1:0];
        if (rd_done) begin
            lanes.dram_index[0] <= rd_data.index_0;
            lanes.dram_index[1] <= rd_data.index_1;
            lanes.dram_index[2] <= rd_data.index_2;
            lanes.dram_index[3] <= rd_data.index_3;
            stored_date.month   <= rd_data.month;
            stored_date.day     <= rd_data.day;
        end
    end

    // Date check needs no indices
    assign req_done = (idx_cnt == CNT_W'(`LANES)) || (action == index_pkg::Check_Valid_Date);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            idx_cnt    <= '0;
            have_rec   <= 1'b0;
            fired      <= 1'b0;
            start      <= 1'b0;
            lanes.load <= '0;
        end else begin
            lanes.load <= {`LANES{rd_done}};
            start      <= 1'b0;
            if (action_valid) begin
                idx_cnt  <= '0;
                have_rec <= 1'b0;
                fired    <= 1'b0;
            end else begin
                if (index_valid)
                    idx_cnt <= idx_cnt + 1'b1;
                if (rd_done)
                    have_rec <= 1'b1;
                if (have_rec && req_done && !fired) begin
                    fired <= 1'b1;
                    start <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/index_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "index_config.svh"

interface index_lane_if;

    logic [`IDX_W-1:0] req_index  [`LANES];
    logic [`IDX_W-1:0] dram_index [`LANES];
    logic [`LANES-1:0] load;       // Record arrived
    logic              ge         [`LANES];
    logic              at_max     [`LANES];
    logic [`IDX_W-1:0] upd_sum    [`LANES];
    logic              sat        [`LANES];

    modport feed  (output req_index, dram_index, load);

    modport lane  (input req_index, dram_index, load,
                   output ge, at_max, upd_sum, sat);

    modport drain (input dram_index, ge, at_max, upd_sum, sat);

endinterface

`default_nettype wire

// File: logic/index_pkg.sv
`default_nettype none

`include "index_config.svh"

package index_pkg;

    typedef enum logic [1:0] {
        Index_Check      = 2'd0,
        Update           = 2'd1,
        Check_Valid_Date = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        Formula_A, Formula_B, Formula_C, Formula_D,
        Formula_E, Formula_F, Formula_G, Formula_H
    } formula_t;

    typedef enum logic [1:0] {
        Insensitive = 2'b00,
        Normal      = 2'b01,
        Sensitive   = 2'b11
    } mode_t;

    typedef enum logic [1:0] {
        No_Warn   = 2'd0,
        Date_Warn = 2'd1,
        Risk_Warn = 2'd2,
        Data_Warn = 2'd3
    } warn_t;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // Memory record with index 0 in the top bits
    typedef struct packed {
        logic [`IDX_W-1:0] index_0;
        logic [`IDX_W-1:0] index_1;
        logic [3:0]        pad_0;
        logic [3:0]        month;
        logic [`IDX_W-1:0] index_2;
        logic [`IDX_W-1:0] index_3;
        logic [2:0]        pad_1;
        logic [4:0]        day;
    } dram_rec_t;

endpackage

`default_nettype wire

// File: logic/index_config.svh
`ifndef INDEX_CONFIG_SVH
`define INDEX_CONFIG_SVH

`define IDX_W       12
`define LANES       4
`define ADDR_W      17
`define DATA_W      64
`define IN_W        12
`define DRAM_BASE   17'h10000   // Records sit 8 bytes apart from record 0

`define THR_A_INS   2047
`define THR_A_NRM   1023
`define THR_A_SEN   511
`define THR_CNT_INS 3
`define THR_CNT_NRM 2
`define THR_CNT_SEN 1

`endif
